/* Makefile */
# Verilator build and run for the cache bank testbench

VERILATOR   ?= verilator
TOP         ?= tb_cache_bank
FILELIST    ?= tb.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing
EXTRA_FLAGS ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS EXTRA_FLAGS"

test:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* hw/cache_bank.sv */
// ------------------------------------------------
// One set-associative cache bank. Takes a request
// opcode each cycle and answers the next cycle
// with valid, hit and the read word.
// ------------------------------------------------

`timescale 1ns/1ns

module cache_bank
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cache_op_e             op,
    input  logic [addr_width-1:0] addr,
    input  logic [word_bytes-1:0] byteen,
    input  logic [word_width-1:0] write_data,
    input  logic [line_width-1:0] fill_data,
    output logic                  rsp_valid,
    output logic                  rsp_hit,
    output logic [word_width-1:0] rsp_data
);

    localparam int SET_BITS = $clog2(NUM_SETS);

    logic is_read;
    logic is_write;
    logic is_fill;
    logic lookup;
    logic req_hit;
    logic data_write;

    logic [word_sel_bits-1:0] wsel;
    logic [SET_BITS-1:0]      set_idx;
    logic [NUM_WAYS-1:0]      hit_ways;
    logic [NUM_WAYS-1:0]      victim_way;
    logic [NUM_WAYS-1:0]      way_sel;

    // Opcode decode
    assign is_read  = (op == op_read);
    assign is_write = (op == op_write);
    assign is_fill  = (op == op_fill);
    assign lookup   = is_read | is_write;

    // Address fields above the byte offset
    assign wsel    = addr[offset_bits-word_sel_bits +: word_sel_bits];
    assign set_idx = addr[offset_bits +: SET_BITS];

    assign req_hit = |hit_ways;

    // Write misses are not allocated and leave the data store alone
    assign data_write = is_write & req_hit;

    // Fills go to the victim, reads and writes to the hit way
    assign way_sel = is_fill ? victim_way : hit_ways;

    cache_tags #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_cache_tags (
        .clk        (clk),
        .arst_n     (arst_n),
        .lookup     (lookup),
        .fill       (is_fill),
        .addr       (addr),
        .hit_ways   (hit_ways),
        .victim_way (victim_way)
    );

    cache_data #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_cache_data (
        .clk        (clk),
        .fill       (is_fill),
        .write      (data_write),
        .set_idx    (set_idx),
        .wsel       (wsel),
        .byteen     (byteen),
        .fill_data  (fill_data),
        .write_data (write_data),
        .way_sel    (way_sel),
        .read_data  (rsp_data)
    );

    // Response flags line up with the registered RAM read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
            rsp_hit   <= 1'b0;
        end else begin
            rsp_valid <= (op != op_none);
            rsp_hit   <= is_fill | req_hit;
        end
    end

endmodule

/* hw/cache_data.sv */
// ------------------------------------------------
// Line data store for one cache bank. Takes full
// line fills and byte-enabled word writes, and
// returns one word a cycle after the address.
// ------------------------------------------------

`timescale 1ns/1ns

module cache_data
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic                        clk,
    input  logic                        fill,
    input  logic                        write,
    input  logic [$clog2(NUM_SETS)-1:0] set_idx,
    input  logic [word_sel_bits-1:0]    wsel,
    input  logic [word_bytes-1:0]       byteen,
    input  logic [line_width-1:0]       fill_data,
    input  logic [word_width-1:0]       write_data,
    input  logic [NUM_WAYS-1:0]         way_sel,
    output logic [word_width-1:0]       read_data
);

    localparam int WAY_BITS  = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int RAM_WIDTH = line_width * NUM_WAYS;
    localparam int RAM_WREN  = word_bytes * words_per_line * NUM_WAYS;

    // Word-major layout with ways innermost, so the way mux comes last
    logic [words_per_line-1:0][NUM_WAYS-1:0][word_width-1:0] ram_wdata;
    logic [words_per_line-1:0][NUM_WAYS-1:0][word_width-1:0] ram_rdata;
    logic [words_per_line-1:0][NUM_WAYS-1:0][word_bytes-1:0] ram_wren;

    logic [words_per_line-1:0][word_width-1:0] fill_words;
    logic [words_per_line-1:0][word_bytes-1:0] write_mask;
    logic [NUM_WAYS-1:0][word_width-1:0]       way_words;

    logic [WAY_BITS-1:0]      way_idx;
    logic [WAY_BITS-1:0]      way_idx_q;
    logic [word_sel_bits-1:0] wsel_q;

    assign fill_words = fill_data;

    // Byte enables land only on the addressed word
    always_comb begin
        write_mask       = '0;
        write_mask[wsel] = byteen;
    end

    for (genvar w = 0; w < words_per_line; w++) begin : g_word
        for (genvar j = 0; j < NUM_WAYS; j++) begin : g_way
            assign ram_wdata[w][j] = fill ? fill_words[w] : write_data;
            assign ram_wren[w][j]  = (fill ? {word_bytes{1'b1}} : write_mask[w])
                                   & {word_bytes{way_sel[j]}};
        end
    end

    // One-hot way select to index
    always_comb begin
        way_idx = '0;
        for (int j = 0; j < NUM_WAYS; j++) begin
            if (way_sel[j]) begin
                way_idx = WAY_BITS'(j);
            end
        end
    end

    cache_sp_ram #(
        .DATA_WIDTH (RAM_WIDTH),
        .DEPTH      (NUM_SETS),
        .WREN_WIDTH (RAM_WREN)
    ) u_data_ram (
        .clk   (clk),
        .write (fill | write),
        .wren  (ram_wren),
        .addr  (set_idx),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    // Selects follow the RAM read by one cycle
    always_ff @(posedge clk) begin
        wsel_q    <= wsel;
        way_idx_q <= way_idx;
    end

    // Word first, then way
    assign way_words = ram_rdata[wsel_q];
    assign read_data = way_words[way_idx_q];

endmodule

/* hw/cache_pkg.sv */
// ------------------------------------------------
// Geometry and request opcodes shared by the
// cache bank RTL. Modules pull these in through a
// wildcard import in their header.
// ------------------------------------------------

package cache_pkg;

    // Word geometry
    localparam int word_bytes = 4;
    localparam int word_width = word_bytes * 8;

    // Line geometry
    localparam int words_per_line = 4;
    localparam int line_width     = word_width * words_per_line;

    // Address split below the set index
    localparam int word_sel_bits = $clog2(words_per_line);
    localparam int offset_bits   = $clog2(word_bytes * words_per_line);

    // Full byte address presented to the bank
    localparam int addr_width = 32;

    // Request opcode, one per cycle
    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2,
        op_fill  = 2'd3
    } cache_op_e;

endpackage

/* hw/cache_sp_ram.sv */
// ------------------------------------------------
// Single-port RAM with per-lane write enables.
// Read data is registered and returns the old
// contents when the same entry is written.
// ------------------------------------------------

`timescale 1ns/1ns

module cache_sp_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 16,
    parameter int WREN_WIDTH = DATA_WIDTH / 8
) (
    input  logic                     clk,
    input  logic                     write,
    input  logic [WREN_WIDTH-1:0]    wren,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [DATA_WIDTH-1:0]    wdata,
    output logic [DATA_WIDTH-1:0]    rdata
);

    // Width of one write-enable lane
    localparam int LANE_WIDTH = DATA_WIDTH / WREN_WIDTH;

    logic [WREN_WIDTH-1:0][LANE_WIDTH-1:0] mem [DEPTH];
    logic [WREN_WIDTH-1:0][LANE_WIDTH-1:0] wlanes;

    assign wlanes = wdata;

    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < WREN_WIDTH; i++) begin
                if (wren[i]) begin
                    mem[addr][i] <= wlanes[i];
                end
            end
        end
        // Registered read returns the previous contents on a same-entry write
        rdata <= mem[addr];
    end

endmodule

/* hw/cache_tags.sv */
// ------------------------------------------------
// Tag and valid store for one cache bank.
// Lookup is combinational per way; a fill writes
// the victim way and advances the per-set pointer.
// ------------------------------------------------

`timescale 1ns/1ns

module cache_tags
    import cache_pkg::*;
#(
    parameter int NUM_SETS = 16,
    parameter int NUM_WAYS = 2
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  lookup,
    input  logic                  fill,
    input  logic [addr_width-1:0] addr,
    output logic [NUM_WAYS-1:0]   hit_ways,
    output logic [NUM_WAYS-1:0]   victim_way
);

    localparam int SET_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = addr_width - offset_bits - SET_BITS;
    localparam int PTR_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    // Tag payload per set and way
    logic [TAG_BITS-1:0] tag_q [NUM_SETS][NUM_WAYS];

    // Control state
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [NUM_SETS-1:0][PTR_BITS-1:0] ptr_q;

    logic [SET_BITS-1:0] set_idx;
    logic [TAG_BITS-1:0] addr_tag;
    logic [PTR_BITS-1:0] victim_idx;
    logic [PTR_BITS-1:0] ptr_next;

    // Address split
    assign set_idx  = addr[offset_bits +: SET_BITS];
    assign addr_tag = addr[addr_width-1 -: TAG_BITS];

    // Current round-robin way for this set
    assign victim_idx = ptr_q[set_idx];

    // Wrap explicitly so non power-of-two way counts work
    assign ptr_next = (victim_idx == PTR_BITS'(NUM_WAYS - 1))
                    ? '0
                    : victim_idx + PTR_BITS'(1);

    // Per-way compare against valid entries
    always_comb begin
        for (int j = 0; j < NUM_WAYS; j++) begin
            hit_ways[j] = lookup
                       && valid_q[set_idx][j]
                       && (tag_q[set_idx][j] == addr_tag);
        end
    end

    // One-hot form of the pointer
    always_comb begin
        victim_way = '0;
        victim_way[victim_idx] = 1'b1;
    end

    // Tag write on fill
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[set_idx][victim_idx] <= addr_tag;
        end
    end

    // Valid bits and victim pointers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (fill) begin
            valid_q[set_idx][victim_idx] <= 1'b1;
            ptr_q[set_idx]               <= ptr_next;
        end
    end

endmodule

/* sim/cache_testdata.txt */
# columns: name opcode(0 none 1 read 2 write 3 fill) address byteen write_word fill_line exp_hit
# all hex, fill_line is word 3 down to word 0, exp_hit is the expected response hit flag
reset_miss 1 00000000 0 00000000 0 0
reset_miss 0 00000000 0 00000000 0 0
reset_miss 1 00000154 0 00000000 0 0
reset_miss 0 00000000 0 00000000 0 0
reset_miss 1 000003f8 0 00000000 0 0
fill_read 3 00001220 0 00000000 44444444333333332222222211111111 1
fill_read 1 00001220 0 00000000 0 1
fill_read 1 00001224 0 00000000 0 1
fill_read 1 00001228 0 00000000 0 1
fill_read 1 0000122c 0 00000000 0 1
fill_read 1 00003420 0 00000000 0 0
two_way 3 0000a030 0 00000000 a3a3a3a3a2a2a2a2a1a1a1a1a0a0a0a0 1
two_way 3 0000b030 0 00000000 b3b3b3b3b2b2b2b2b1b1b1b1b0b0b0b0 1
two_way 1 0000a030 0 00000000 0 1
two_way 1 0000b034 0 00000000 0 1
evict 3 0000c030 0 00000000 c3c3c3c3c2c2c2c2c1c1c1c1c0c0c0c0 1
evict 1 0000a034 0 00000000 0 0
evict 1 0000b038 0 00000000 0 1
evict 1 0000c03c 0 00000000 0 1
partial_write 2 00001224 3 aabbccdd 0 1
partial_write 1 00001224 0 00000000 0 1
partial_write 2 00001228 8 99000000 0 1
partial_write 1 00001228 0 00000000 0 1
partial_write 2 00001220 5 12345678 0 1
partial_write 1 00001220 0 00000000 0 1
partial_write 1 0000122c 0 00000000 0 1
write_miss 2 00003424 f deadbeef 0 0
write_miss 2 0000a034 f deadbeef 0 0
write_miss 1 00001224 0 00000000 0 1
write_miss 1 00003424 0 00000000 0 0
write_miss 1 0000b034 0 00000000 0 1
write_miss 1 0000c034 0 00000000 0 1
write_miss 0 00000000 0 00000000 0 0

/* sim/tb_cache_model.svh */
// ------------------------------------------------
// Reference model of the cache bank. Tracks tags,
// valid bits, victim pointers and line data, and
// predicts the hit flag and read word per request.
// ------------------------------------------------

logic [addr_width-1:0] model_tag   [NUM_SETS][NUM_WAYS];
bit                    model_valid [NUM_SETS][NUM_WAYS];
int                    model_ptr   [NUM_SETS];
logic [word_width-1:0] model_word  [NUM_SETS][NUM_WAYS][words_per_line];

task automatic model_reset();
    for (int s = 0; s < NUM_SETS; s++) begin
        model_ptr[s] = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            model_valid[s][w] = 1'b0;
        end
    end
endtask

// Predict one request, then apply its effect on the stored state
task automatic model_request(
    input  cache_op_e             kind,
    input  logic [addr_width-1:0] a,
    input  logic [word_bytes-1:0] be,
    input  logic [word_width-1:0] wd,
    input  logic [line_width-1:0] fl,
    output bit                    hit,
    output logic [word_width-1:0] rd
);
    int                    set_i;
    int                    word_i;
    int                    way_i;
    logic [addr_width-1:0] tag;

    set_i  = int'((a >> offset_bits) % NUM_SETS);
    word_i = int'((a >> (offset_bits - word_sel_bits)) % words_per_line);
    tag    = a >> (offset_bits + $clog2(NUM_SETS));
    hit    = 1'b0;
    way_i  = 0;
    rd     = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
        if (model_valid[set_i][w] && model_tag[set_i][w] == tag) begin
            hit   = 1'b1;
            way_i = w;
        end
    end
    if (kind == op_read && hit) begin
        rd = model_word[set_i][way_i][word_i];
    end else if (kind == op_write && hit) begin
        for (int b = 0; b < word_bytes; b++) begin
            if (be[b]) begin
                model_word[set_i][way_i][word_i][8*b +: 8] = wd[8*b +: 8];
            end
        end
    end else if (kind == op_fill) begin
        // Victim is the round-robin way whatever the ways already hold
        way_i = model_ptr[set_i];
        model_tag[set_i][way_i]   = tag;
        model_valid[set_i][way_i] = 1'b1;
        for (int k = 0; k < words_per_line; k++) begin
            model_word[set_i][way_i][k] = fl[k*word_width +: word_width];
        end
        model_ptr[set_i] = (model_ptr[set_i] + 1) % NUM_WAYS;
        hit = 1'b1;
    end
endtask

/* sim/tb_cache_bank.sv */
// ------------------------------------------------
// Testbench for the cache bank. Replays requests
// from the testdata file and checks each response
// against the reference model one cycle later.
// ------------------------------------------------

`timescale 1ns/1ns

module tb_cache_bank
    import cache_pkg::*;
();

    localparam int NUM_SETS      = 16;
    localparam int NUM_WAYS      = 2;
    localparam int CLK_HALF      = 50;
    localparam int RESET_CYCLES  = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int RESET_TIMEOUT = 20;
    localparam int MAX_CYCLES    = 500;

    logic                  clk;
    logic                  arst_n;
    cache_op_e             op;
    logic [addr_width-1:0] addr;
    logic [word_bytes-1:0] byteen;
    logic [word_width-1:0] write_data;
    logic [line_width-1:0] fill_data;
    logic                  rsp_valid;
    logic                  rsp_hit;
    logic [word_width-1:0] rsp_data;

    // Current request as read from the data file
    int              fd;
    int              line_no;
    int              checks_done;
    logic [8*16-1:0] req_name;
    logic [31:0]     req_op;
    logic [31:0]     req_addr;
    logic [31:0]     req_be;
    logic [31:0]     req_wd;
    logic [127:0]    req_fill;
    logic [31:0]     req_exp_hit;

    // Expectations for the response due next cycle
    logic [8*16-1:0] exp_name;
    int              exp_line;
    bit              exp_valid;
    bit              exp_hit;
    bit              exp_check_data;
    logic [31:0]     exp_file_hit;
    logic [31:0]     exp_data;

    `include "tb_cache_model.svh"

    cache_bank #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS)
    ) u_cache_bank (
        .clk        (clk),
        .arst_n     (arst_n),
        .op         (op),
        .addr       (addr),
        .byteen     (byteen),
        .write_data (write_data),
        .fill_data  (fill_data),
        .rsp_valid  (rsp_valid),
        .rsp_hit    (rsp_hit),
        .rsp_data   (rsp_data)
    );

    always #CLK_HALF clk = ~clk;

    initial begin : reset_gen
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %0s: expected %0h, actual %0h", what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end else begin
            checks_done++;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout while %0s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // Skips comment and blank lines and clears got at end of file
    task automatic fetch_request(output bit got);
        string text_line;
        int    rc;
        int    fields;

        got = 1'b0;
        while (!got && !$feof(fd)) begin
            rc = $fgets(text_line, fd);
            line_no++;
            if (rc != 0 && text_line.len() > 1 && text_line[0] != "#") begin
                fields = $sscanf(text_line, "%s %h %h %h %h %h %h", req_name, req_op,
                                 req_addr, req_be, req_wd, req_fill, req_exp_hit);
                if (fields != 7) begin
                    $display("Malformed request on line %0d of the data file", line_no);
                    $display("CHECKS FAILED");
                    $fatal(1);
                end else begin
                    got = 1'b1;
                end
            end
        end
    endtask

    task automatic check_response();
        string label;

        label = $sformatf("%0s line %0d", exp_name, exp_line);
        check_value({label, " rsp_valid"}, 32'(exp_valid), 32'(rsp_valid));
        if (exp_valid) begin
            check_value({label, " rsp_hit"}, 32'(exp_hit), 32'(rsp_hit));
            check_value({label, " rsp_hit per data file"}, exp_file_hit, 32'(rsp_hit));
        end
        if (exp_check_data) begin
            check_value({label, " rsp_data"}, exp_data, rsp_data);
        end
    endtask

    initial begin : stimulus
        int                    cycles;
        bit                    more;
        bit                    pending;
        bit                    m_hit;
        logic [word_width-1:0] m_data;

        clk         = 1'b0;
        op          = op_none;
        addr        = '0;
        byteen      = '0;
        write_data  = '0;
        fill_data   = '0;
        checks_done = 0;
        line_no     = 0;
        more        = 1'b1;
        pending     = 1'b0;
        model_reset();
        fd = $fopen("sim/cache_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/cache_testdata.txt");
            $display("CHECKS FAILED");
            $fatal(1);
        end

        cycles = 0;
        while (arst_n !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                stop_on_timeout("waiting for reset release");
            end
            @(posedge clk);
            cycles++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        check_value("after_reset rsp_valid", 32'd0, 32'(rsp_valid));

        // Each cycle checks the previous response, then drives the next request
        cycles = 0;
        while (more || pending) begin
            if (cycles >= MAX_CYCLES) begin
                stop_on_timeout("replaying the data file");
            end
            if (pending) begin
                check_response();
            end
            fetch_request(more);
            if (more) begin
                op         = cache_op_e'(req_op[1:0]);
                addr       = req_addr;
                byteen     = req_be[word_bytes-1:0];
                write_data = req_wd;
                fill_data  = req_fill;
                model_request(op, addr, byteen, write_data, fill_data, m_hit, m_data);
                exp_name       = req_name;
                exp_line       = line_no;
                exp_valid      = (op == op_read) || (op == op_write) || (op == op_fill);
                exp_hit        = m_hit;
                exp_check_data = (op == op_read) && m_hit;
                exp_file_hit   = req_exp_hit;
                exp_data       = m_data;
                pending        = 1'b1;
            end else begin
                op      = op_none;
                pending = 1'b0;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        check_value("final_idle rsp_valid", 32'd0, 32'(rsp_valid));
        $fclose(fd);

        if (checks_done == 0) begin
            $display("No responses were checked, the data file holds no requests");
            $display("CHECKS FAILED");
            $fatal(1);
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* tb.f */
+incdir+sim
hw/cache_pkg.sv
hw/cache_sp_ram.sv
hw/cache_tags.sv
hw/cache_data.sv
hw/cache_bank.sv
sim/tb_cache_bank.sv
